//--- source/dma_pkg.sv
// shared widths, depths, direction codes and the byte/nibble entry type of the dma
`default_nettype none

package dma_pkg;

    localparam int BYTE_W    = 8;   // cpu side data width
    localparam int NIBBLE_W  = 4;   // memory side data width
    localparam int BUF_DEPTH = 8;   // entries per ping-pong buffer
    localparam int PTR_W     = 3;   // entry pointer width
    localparam int ADDR_W    = 32;
    localparam int LEN_W     = 32;  // length and beat counters

    // direction of the current descriptor
    localparam logic DIR_CPU_TO_MEM = 1'b1;
    localparam logic DIR_MEM_TO_CPU = 1'b0;

    // one entry seen as two nibbles, low half moves first
    typedef struct packed {
        logic [NIBBLE_W-1:0] hi;
        logic [NIBBLE_W-1:0] lo;
    } nibble_pair_t;

    // same entry read whole on the byte side
    typedef union packed {
        logic [BYTE_W-1:0] whole;
        nibble_pair_t      nib;
    } byte_nibble_u;

endpackage

`default_nettype wire

//--- source/nibble_buffer.sv
// ping-pong half, eight entries filled then drained with byte/nibble width conversion
`default_nettype none

module nibble_buffer (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       direction,  // sampled with the descriptor
    input  logic                       wr_valid,
    input  logic [dma_pkg::BYTE_W-1:0] wr_data,    // nibbles arrive in the low bits
    output logic                       wr_ready,
    output logic                       rd_valid,
    output logic [dma_pkg::BYTE_W-1:0] rd_data,    // nibbles leave in the low bits
    input  logic                       rd_ready,
    output logic                       filling
);
    import dma_pkg::*;

    byte_nibble_u     entry [BUF_DEPTH];  // payload storage
    byte_nibble_u     cur;                // entry under the pointer
    logic [PTR_W-1:0] ptr;
    logic             half;               // high nibble is next
    logic             draining;           // phase bit, low while filling
    logic             nibble_mode;        // unit width of the current phase
    logic             wr_fire;
    logic             rd_fire;
    logic             last_unit;

    // cpu-to-mem takes bytes and gives nibbles
    // mem-to-cpu takes nibbles and gives bytes
    assign nibble_mode = (direction == DIR_CPU_TO_MEM) ? draining : !draining;

    assign wr_ready = !draining;  // whole fill phase
    assign rd_valid = draining;   // whole drain phase
    assign filling  = !draining;

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // last entry, and its high half when moving nibbles
    assign last_unit = (ptr == PTR_W'(BUF_DEPTH - 1)) && (!nibble_mode || half);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            draining <= 1'b0;  // start empty in fill phase
            ptr      <= '0;
            half     <= 1'b0;
        end
        else if (wr_fire || rd_fire)
        begin
            if (nibble_mode && !half)
                half <= 1'b1;  // low half done
            else
            begin
                half <= 1'b0;
                ptr  <= ptr + 1'b1;  // wraps back to entry 0
            end
            if (last_unit)
                draining <= !draining;  // phase flips for the next cycle
        end
    end

    // entry writes
    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            if (!nibble_mode)
                entry[ptr].whole <= wr_data;
            else if (half)
                entry[ptr].nib.hi <= wr_data[NIBBLE_W-1:0];
            else
                entry[ptr].nib.lo <= wr_data[NIBBLE_W-1:0];
        end
    end

    assign cur = entry[ptr];

    // read mux, zero padded in nibble mode
    always_comb
    begin
        if (!nibble_mode)
            rd_data = cur.whole;
        else if (half)
            rd_data = {{(BYTE_W - NIBBLE_W){1'b0}}, cur.nib.hi};
        else
            rd_data = {{(BYTE_W - NIBBLE_W){1'b0}}, cur.nib.lo};
    end

    // the unit width must hold for a whole phase
    a_dir_stable: assert property (@(posedge clk) disable iff (!resetn)
        ((ptr != '0) || half) |-> $stable(direction))
        else $error("nibble_buffer: direction changed mid-phase");

endmodule

`default_nettype wire

//--- source/pingpong_datapath.sv
// two nibble buffers in ping-pong, steered by direction and gated by the open channels
`default_nettype none

module pingpong_datapath (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         direction,
    input  logic                         cpu_open,
    input  logic                         mem_open,
    input  logic                         cpu_wvalid,
    input  logic [dma_pkg::BYTE_W-1:0]   cpu_wdata,
    output logic                         cpu_wready,
    output logic                         cpu_rvalid,
    output logic [dma_pkg::BYTE_W-1:0]   cpu_rdata,
    input  logic                         cpu_rready,
    output logic                         mem_wvalid,
    output logic [dma_pkg::NIBBLE_W-1:0] mem_wdata,
    input  logic                         mem_wready,
    input  logic                         mem_rvalid,
    input  logic [dma_pkg::NIBBLE_W-1:0] mem_rdata,
    output logic                         mem_rready,
    output logic                         cpu_beat,
    output logic                         mem_beat
);
    import dma_pkg::*;

    logic              c2m;          // cpu-to-mem descriptor
    logic              in_sel;       // buffer being filled, 0 is buf_a
    logic              fill_valid;
    logic [BYTE_W-1:0] fill_data;
    logic              fill_ready;
    logic              drain_valid;
    logic [BYTE_W-1:0] drain_data;
    logic              drain_ready;
    logic              sel_full;     // fill buffer has turned to drain
    logic              other_empty;  // drain buffer is back in fill
    logic              swap;
    logic              a_wr_ready;
    logic              a_rd_valid;
    logic [BYTE_W-1:0] a_rd_data;
    logic              a_filling;
    logic              b_wr_ready;
    logic              b_rd_valid;
    logic [BYTE_W-1:0] b_rd_data;
    logic              b_filling;

    assign c2m = (direction == DIR_CPU_TO_MEM);

    // fill side is cpu write or memory read
    assign fill_valid = c2m ? (cpu_wvalid && cpu_open) : (mem_rvalid && mem_open);
    assign fill_data  = c2m ? cpu_wdata : {{(BYTE_W - NIBBLE_W){1'b0}}, mem_rdata};
    // drain side is memory write or cpu read
    assign drain_ready = c2m ? (mem_wready && mem_open) : (cpu_rready && cpu_open);

    nibble_buffer buf_a (
        .clk       (clk),
        .resetn    (resetn),
        .direction (direction),
        .wr_valid  (fill_valid && !in_sel),
        .wr_data   (fill_data),
        .wr_ready  (a_wr_ready),
        .rd_valid  (a_rd_valid),
        .rd_data   (a_rd_data),
        .rd_ready  (drain_ready && in_sel),
        .filling   (a_filling)
    );

    nibble_buffer buf_b (
        .clk       (clk),
        .resetn    (resetn),
        .direction (direction),
        .wr_valid  (fill_valid && in_sel),
        .wr_data   (fill_data),
        .wr_ready  (b_wr_ready),
        .rd_valid  (b_rd_valid),
        .rd_data   (b_rd_data),
        .rd_ready  (drain_ready && !in_sel),
        .filling   (b_filling)
    );

    assign fill_ready  = in_sel ? b_wr_ready : a_wr_ready;
    assign drain_valid = in_sel ? a_rd_valid : b_rd_valid;  // drain from the other one
    assign drain_data  = in_sel ? a_rd_data : b_rd_data;

    // outward handshakes, masked by direction and open flags
    assign cpu_wready = c2m && cpu_open && fill_ready;
    assign mem_rready = !c2m && mem_open && fill_ready;
    assign mem_wvalid = c2m && mem_open && drain_valid;
    assign cpu_rvalid = !c2m && cpu_open && drain_valid;
    assign mem_wdata  = drain_data[NIBBLE_W-1:0];
    assign cpu_rdata  = drain_data;

    // one pulse per completed beat on each side
    assign cpu_beat = (cpu_wvalid && cpu_wready) || (cpu_rvalid && cpu_rready);
    assign mem_beat = (mem_wvalid && mem_wready) || (mem_rvalid && mem_rready);

    assign sel_full    = in_sel ? !b_filling : !a_filling;
    assign other_empty = in_sel ? a_filling : b_filling;
    assign swap        = sel_full && other_empty;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            in_sel <= 1'b0;  // buf_a fills first
        else if (swap)
            in_sel <= !in_sel;
    end

    // both channels closed means every buffer load has drained
    a_idle_empty: assert property (@(posedge clk) disable iff (!resetn)
        (!cpu_open && !mem_open) |-> (a_filling && b_filling))
        else $error("pingpong_datapath: buffer holds data with both channels closed");

endmodule

`default_nettype wire

//--- source/descriptor_ctrl.sv
// descriptor handshakes, length and direction registers, beat counting and channel open flags
`default_nettype none

module descriptor_ctrl (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       address_in_valid,
    input  logic [dma_pkg::ADDR_W-1:0] addr_in,
    input  logic [dma_pkg::LEN_W-1:0]  len_in,
    input  logic                       dir_in,
    output logic                       address_in_enable,
    output logic                       address_out_valid,
    output logic [dma_pkg::ADDR_W-1:0] addr_out,
    output logic [dma_pkg::LEN_W-1:0]  len_out,
    input  logic                       address_out_enable,
    input  logic                       cpu_beat,
    input  logic                       mem_beat,
    output logic                       direction,
    output logic                       cpu_open,
    output logic                       mem_open
);
    import dma_pkg::*;

    logic [LEN_W-1:0] cpu_cnt;   // bytes on the cpu side
    logic [LEN_W-1:0] mem_cnt;   // nibbles on the memory side
    logic [LEN_W-1:0] len_nib;   // length in nibbles
    logic             desc_in_fire;
    logic             desc_out_fire;
    logic             cpu_last;
    logic             mem_last;
    logic             all_done;

    assign desc_in_fire  = address_in_valid && address_in_enable;
    assign desc_out_fire = address_out_valid && address_out_enable;
    assign len_nib       = len_out << 1;

    assign cpu_last = cpu_beat && (cpu_cnt == len_out - 1'b1);
    assign mem_last = mem_beat && (mem_cnt == len_nib - 1'b1);
    // both sides have moved the full length
    assign all_done = !address_in_enable && (cpu_cnt == len_out) && (mem_cnt == len_nib);

    // descriptor payload
    always_ff @(posedge clk)
    begin
        if (desc_in_fire)
        begin
            addr_out <= addr_in;
            len_out  <= len_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            address_in_enable <= 1'b1;  // ready for the first descriptor
            address_out_valid <= 1'b0;
            direction         <= DIR_MEM_TO_CPU;
            cpu_open          <= 1'b0;
            mem_open          <= 1'b0;
            cpu_cnt           <= '0;
            mem_cnt           <= '0;
        end
        else
        begin
            if (desc_in_fire)
            begin
                address_in_enable <= 1'b0;
                address_out_valid <= 1'b1;  // pass on to memory
                direction         <= dir_in;
                cpu_open          <= 1'b1;
                cpu_cnt           <= '0;
                mem_cnt           <= '0;
            end
            else if (all_done)
                address_in_enable <= 1'b1;  // next descriptor
            if (desc_out_fire)
            begin
                address_out_valid <= 1'b0;
                mem_open          <= 1'b1;
            end
            if (cpu_beat)
                cpu_cnt <= cpu_cnt + 1'b1;
            if (cpu_last)
                cpu_open <= 1'b0;  // close on the final byte
            if (mem_beat)
                mem_cnt <= mem_cnt + 1'b1;
            if (mem_last)
                mem_open <= 1'b0;  // close on the final nibble
        end
    end

    // buffers only drain whole, so lengths come in full buffer loads
    a_len_legal: assert property (@(posedge clk) disable iff (!resetn)
        desc_in_fire |-> (len_in != '0) && ((len_in % LEN_W'(BUF_DEPTH)) == '0))
        else $error("descriptor_ctrl: length not a non-zero multiple of the buffer depth");

    a_cpu_beat_open: assert property (@(posedge clk) disable iff (!resetn)
        cpu_beat |-> cpu_open)
        else $error("descriptor_ctrl: cpu beat on a closed channel");

    a_mem_beat_open: assert property (@(posedge clk) disable iff (!resetn)
        mem_beat |-> mem_open)
        else $error("descriptor_ctrl: memory beat on a closed channel");

    a_desc_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(address_in_enable && address_out_valid))
        else $error("descriptor_ctrl: descriptor input and output active together");

endmodule

`default_nettype wire

//--- source/dma_top.sv
// ping-pong dma top, joins the descriptor controller and the buffered datapath
`default_nettype none

module dma_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         address_in_valid,
    input  logic [dma_pkg::ADDR_W-1:0]   addr_in,
    input  logic [dma_pkg::LEN_W-1:0]    len_in,
    input  logic                         dir_in,
    output logic                         address_in_enable,
    output logic                         address_out_valid,
    output logic [dma_pkg::ADDR_W-1:0]   addr_out,
    output logic [dma_pkg::LEN_W-1:0]    len_out,
    input  logic                         address_out_enable,
    input  logic                         cpu_wvalid,
    input  logic [dma_pkg::BYTE_W-1:0]   cpu_wdata,
    output logic                         cpu_wready,
    output logic                         cpu_rvalid,
    output logic [dma_pkg::BYTE_W-1:0]   cpu_rdata,
    input  logic                         cpu_rready,
    output logic                         mem_wvalid,
    output logic [dma_pkg::NIBBLE_W-1:0] mem_wdata,
    input  logic                         mem_wready,
    input  logic                         mem_rvalid,
    input  logic [dma_pkg::NIBBLE_W-1:0] mem_rdata,
    output logic                         mem_rready
);

    logic direction;  // sampled per descriptor
    logic cpu_open;
    logic mem_open;
    logic cpu_beat;   // beat pulses back to the counters
    logic mem_beat;

    descriptor_ctrl u_ctrl (
        .clk                (clk),
        .resetn             (resetn),
        .address_in_valid   (address_in_valid),
        .addr_in            (addr_in),
        .len_in             (len_in),
        .dir_in             (dir_in),
        .address_in_enable  (address_in_enable),
        .address_out_valid  (address_out_valid),
        .addr_out           (addr_out),
        .len_out            (len_out),
        .address_out_enable (address_out_enable),
        .cpu_beat           (cpu_beat),
        .mem_beat           (mem_beat),
        .direction          (direction),
        .cpu_open           (cpu_open),
        .mem_open           (mem_open)
    );

    pingpong_datapath u_datapath (
        .clk        (clk),
        .resetn     (resetn),
        .direction  (direction),
        .cpu_open   (cpu_open),
        .mem_open   (mem_open),
        .cpu_wvalid (cpu_wvalid),
        .cpu_wdata  (cpu_wdata),
        .cpu_wready (cpu_wready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .cpu_rready (cpu_rready),
        .mem_wvalid (mem_wvalid),
        .mem_wdata  (mem_wdata),
        .mem_wready (mem_wready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_rready (mem_rready),
        .cpu_beat   (cpu_beat),
        .mem_beat   (mem_beat)
    );

endmodule

`default_nettype wire

//--- dv/dma_tb_vectors.svh
// descriptor table for the dma testbench, one transfer per row
`ifndef DMA_TB_VECTORS_SVH
`define DMA_TB_VECTORS_SVH

localparam int NUM_VECTORS = 8;

string       vec_name [NUM_VECTORS];
logic        vec_dir [NUM_VECTORS];
logic [31:0] vec_addr [NUM_VECTORS];
logic [31:0] vec_len [NUM_VECTORS];        // bytes, whole buffer loads only
int          vec_cpu_stall [NUM_VECTORS];  // percent of cycles the cpu holds off
int          vec_mem_stall [NUM_VECTORS];  // same for the memory

task automatic add_vector(input int idx, input string name, input logic dir,
                          input logic [31:0] addr, input logic [31:0] len,
                          input int cpu_stall, input int mem_stall);
    vec_name[idx]      = name;
    vec_dir[idx]       = dir;
    vec_addr[idx]      = addr;
    vec_len[idx]       = len;
    vec_cpu_stall[idx] = cpu_stall;
    vec_mem_stall[idx] = mem_stall;
endtask

// columns: row, name, direction, address, length, cpu stall %, memory stall %
// directions alternate so every row turns the buffers around
task automatic load_vectors();
    add_vector(0, "c2m_len8_free", DIR_CPU_TO_MEM, 32'h0000_1000, 32'd8, 0, 0);
    add_vector(1, "m2c_len8_free", DIR_MEM_TO_CPU, 32'h0000_2000, 32'd8, 0, 0);
    add_vector(2, "c2m_len16_cpu_stall", DIR_CPU_TO_MEM, 32'h0000_3010, 32'd16, 40, 0);
    add_vector(3, "m2c_len16_mem_stall", DIR_MEM_TO_CPU, 32'h0001_0000, 32'd16, 0, 40);
    add_vector(4, "c2m_len24_both_stall", DIR_CPU_TO_MEM, 32'h8000_0040, 32'd24, 30, 30);
    add_vector(5, "m2c_len24_both_stall", DIR_MEM_TO_CPU, 32'hdead_0100, 32'd24, 30, 50);
    add_vector(6, "c2m_len16_heavy", DIR_CPU_TO_MEM, 32'h0000_ff00, 32'd16, 60, 60);
    add_vector(7, "m2c_len8_heavy", DIR_MEM_TO_CPU, 32'h1234_5678, 32'd8, 60, 20);
endtask

`endif

//--- dv/dma_tb.sv
// dma testbench, table driven descriptors through behavioral cpu and memory models
`default_nettype none

module dma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int WAIT_LIMIT = 64;    // descriptor handshakes
    localparam int DONE_LIMIT = 4;     // last beat to address_in_enable
    localparam int DATA_LIMIT = 4000;  // one whole transfer

    logic                clk;
    logic                resetn;
    logic                address_in_valid;
    logic [ADDR_W-1:0]   addr_in;
    logic [LEN_W-1:0]    len_in;
    logic                dir_in;
    logic                address_in_enable;
    logic                address_out_valid;
    logic [ADDR_W-1:0]   addr_out;
    logic [LEN_W-1:0]    len_out;
    logic                address_out_enable;
    logic                cpu_wvalid;
    logic [BYTE_W-1:0]   cpu_wdata;
    logic                cpu_wready;
    logic                cpu_rvalid;
    logic [BYTE_W-1:0]   cpu_rdata;
    logic                cpu_rready;
    logic                mem_wvalid;
    logic [NIBBLE_W-1:0] mem_wdata;
    logic                mem_wready;
    logic                mem_rvalid;
    logic [NIBBLE_W-1:0] mem_rdata;
    logic                mem_rready;

    logic [31:0]         rng_state;  // lcg
    int                  err_count;
    int                  timeout_count;
    logic                aborted;    // stop after a timeout
    string               cur_name;
    logic [BYTE_W-1:0]   cpu_tx [$];    // bytes the cpu still writes
    logic [BYTE_W-1:0]   cpu_rx [$];    // bytes read back by the cpu
    logic [NIBBLE_W-1:0] mem_tx [$];    // nibbles the memory still supplies
    logic [NIBBLE_W-1:0] mem_rx [$];    // nibbles captured by the memory
    logic [BYTE_W-1:0]   exp_byte [$];
    logic [NIBBLE_W-1:0] exp_nib [$];

    `include "dma_tb_vectors.svh"

    dma_top uut (.*);

    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // true on a cycle where a side holds off
    function automatic logic holds_off(input int pct);
        logic [31:0] r;
        r = next_rand();
        return (int'(r[30:16]) % 100) < pct;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            err_count++;
            $display("ERR %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out, %s", cur_name, what);
        timeout_count++;
        aborted = 1'b1;
    endtask

    // engine waiting for a descriptor, nothing else moves
    task automatic expect_idle();
        check_value("address_in_enable", 32'd1, 32'(address_in_enable));
        check_value("address_out_valid", 32'd0, 32'(address_out_valid));
        check_value("cpu_wready", 32'd0, 32'(cpu_wready));
        check_value("cpu_rvalid", 32'd0, 32'(cpu_rvalid));
        check_value("mem_wvalid", 32'd0, 32'(mem_wvalid));
        check_value("mem_rready", 32'd0, 32'(mem_rready));
    endtask

    task automatic build_streams(input logic [LEN_W-1:0] len, input logic c2m);
        logic [31:0] r;
        cpu_tx.delete();
        cpu_rx.delete();
        mem_tx.delete();
        mem_rx.delete();
        exp_byte.delete();
        exp_nib.delete();
        for (int k = 0; k < int'(len); k++)
        begin
            r = next_rand();
            if (c2m)
            begin
                cpu_tx.push_back(r[23:16]);
                exp_nib.push_back(r[19:16]);  // low half leaves first
                exp_nib.push_back(r[23:20]);
            end
            else
            begin
                mem_tx.push_back(r[19:16]);
                mem_tx.push_back(r[27:24]);
                exp_byte.push_back({r[27:24], r[19:16]});  // first nibble lands low
            end
        end
    endtask

    // cpu descriptor in, then the memory side takes it over
    task automatic pass_descriptor(input int idx);
        logic fired;
        fired = 1'b0;
        address_in_valid <= 1'b1;
        addr_in          <= vec_addr[idx];
        len_in           <= vec_len[idx];
        dir_in           <= vec_dir[idx];
        for (int n = 0; n < WAIT_LIMIT && !fired; n++)
        begin
            @(posedge clk);
            fired = address_in_valid && address_in_enable;
        end
        address_in_valid <= 1'b0;
        if (!fired)
            report_timeout("the cpu descriptor was never accepted");
        else
        begin
            @(posedge clk);
            check_value("address_in_enable after descriptor", 32'd0, 32'(address_in_enable));
            check_value("address_out_valid after descriptor", 32'd1, 32'(address_out_valid));
            check_value("addr_out", vec_addr[idx], addr_out);
            check_value("len_out", vec_len[idx], len_out);
            fired = 1'b0;
            for (int n = 0; n < WAIT_LIMIT && !fired; n++)
            begin
                address_out_enable <= !holds_off(vec_mem_stall[idx]);  // memory may dawdle
                @(posedge clk);
                fired = address_out_valid && address_out_enable;
            end
            address_out_enable <= 1'b0;
            if (!fired)
                report_timeout("the memory never took the descriptor");
            else
            begin
                @(posedge clk);
                check_value("address_out_valid after memory", 32'd0, 32'(address_out_valid));
            end
        end
    endtask

    task automatic move_data(input int idx, input logic c2m);
        logic cpu_taken;
        logic mem_taken;
        logic done;
        int   settle;  // cycles since every expected beat
        cpu_taken = 1'b0;
        mem_taken = 1'b0;
        done      = 1'b0;
        settle    = 0;
        for (int n = 0; n < DATA_LIMIT && !done && !aborted; n++)
        begin
            if (c2m)
            begin
                if (!cpu_wvalid || cpu_taken)  // an offered byte waits until taken
                begin
                    cpu_wvalid <= (cpu_tx.size() > 0) && !holds_off(vec_cpu_stall[idx]);
                    if (cpu_tx.size() > 0)
                        cpu_wdata <= cpu_tx[0];
                end
                mem_wready <= !holds_off(vec_mem_stall[idx]);
            end
            else
            begin
                if (!mem_rvalid || mem_taken)
                begin
                    mem_rvalid <= (mem_tx.size() > 0) && !holds_off(vec_mem_stall[idx]);
                    if (mem_tx.size() > 0)
                        mem_rdata <= mem_tx[0];
                end
                cpu_rready <= !holds_off(vec_cpu_stall[idx]);
            end
            @(posedge clk);
            cpu_taken = cpu_wvalid && cpu_wready;
            mem_taken = mem_rvalid && mem_rready;
            if (cpu_taken)
                void'(cpu_tx.pop_front());
            if (mem_taken)
                void'(mem_tx.pop_front());
            if (cpu_rvalid && cpu_rready)
                cpu_rx.push_back(cpu_rdata);
            if (mem_wvalid && mem_wready)
                mem_rx.push_back(mem_wdata);
            done = address_in_enable;
            if (!done && cpu_tx.size() == 0 && mem_tx.size() == 0
                && cpu_rx.size() == exp_byte.size() && mem_rx.size() == exp_nib.size())
                settle++;
            if (settle > DONE_LIMIT)
                report_timeout("address_in_enable stayed low after the last beat");
        end
        if (!done && !aborted)
            report_timeout("the transfer never finished");
        cpu_wvalid <= 1'b0;
        mem_rvalid <= 1'b0;
        cpu_rready <= 1'b0;
        mem_wready <= 1'b0;
        check_value("nibble count", 32'(exp_nib.size()), 32'(mem_rx.size()));
        check_value("byte count", 32'(exp_byte.size()), 32'(cpu_rx.size()));
        foreach (exp_nib[k])
            if (k < mem_rx.size())
                check_value($sformatf("nibble %0d", k), 32'(exp_nib[k]), 32'(mem_rx[k]));
        foreach (exp_byte[k])
            if (k < cpu_rx.size())
                check_value($sformatf("byte %0d", k), 32'(exp_byte[k]), 32'(cpu_rx[k]));
        @(posedge clk);
        if (!aborted)
            expect_idle();
    endtask

    task automatic run_vector(input int idx);
        logic c2m;
        cur_name = vec_name[idx];
        c2m      = (vec_dir[idx] == DIR_CPU_TO_MEM);
        build_streams(vec_len[idx], c2m);
        pass_descriptor(idx);
        if (!aborted)
            move_data(idx, c2m);
    endtask

    initial
    begin
        clk                = 1'b0;
        rng_state          = 32'd33401;
        err_count          = 0;
        timeout_count      = 0;
        aborted            = 1'b0;
        cur_name           = "reset";
        resetn             <= 1'b0;
        address_in_valid   <= 1'b0;
        addr_in            <= '0;
        len_in             <= '0;
        dir_in             <= 1'b0;
        address_out_enable <= 1'b0;
        cpu_wvalid         <= 1'b0;
        cpu_wdata          <= '0;
        cpu_rready         <= 1'b0;
        mem_wready         <= 1'b0;
        mem_rvalid         <= 1'b0;
        mem_rdata          <= '0;
        load_vectors();
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        expect_idle();
        for (int i = 0; i < NUM_VECTORS && !aborted; i++)
            run_vector(i);
        $display("closing report: %0d value errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- pingpong_dma.f
+incdir+dv
source/dma_pkg.sv
source/nibble_buffer.sv
source/pingpong_datapath.sv
source/descriptor_ctrl.sv
source/dma_top.sv
dv/dma_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dma testbench with verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module dma_tb \
    -f pingpong_dma.f -o dma_sim > "$log" 2>&1 \
    && ./obj_dir/dma_sim >> "$log" 2>&1 \
    || { echo "build or simulation error, see $log"; exit 1; }
grep -q "TEST FAILED" "$log" && { echo "simulation failed, see $log"; exit 1; } \
    || echo "simulation passed"
